//--- list.f
+incdir+include
source/vdp_pkg.sv
source/vram_req_if.sv
source/vdp_host_port.sv
source/vdp_vram_slot.sv
source/vdp_frame_timer.sv
source/vdp_core.sv
tb/vram_model.sv
tb/tb_vdp_core.sv

//--- tb/tb_vdp_core.sv
//----------------------------------------------------------
// Testbench for the VDP host side. Drives the CPU bus of
// vdp_core through control, data and status accesses, keeps
// a shadow copy of VRAM and checks DBI and INT_N against it.
// Compile with list.f and run tb_vdp_core as top.
//----------------------------------------------------------

`include "vdp_consts.svh"

module tb_vdp_core import vdp_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     clk_ns       = 100;
  localparam int     frame_cycles = `FRAME_LINES * `LINE_CYCLES;
  localparam int     ack_limit    = 20;
  localparam longint watchdog_ns  = 64'd6 * 4 * frame_cycles * clk_ns
                                  + 64'd200 * ack_limit * clk_ns;

  // RESET clocks the design and CLK21M resets it
  logic                  reset;
  logic                  clk21m;
  logic                  req;
  logic                  ack;
  logic                  wrt;
  port_mode_e            mode;
  logic [`DATA_W-1:0]    dbi;
  logic [`DATA_W-1:0]    dbo;
  logic                  int_n;
  logic                  pramwe_n;
  logic [`RAM_AW-1:0]    pramadr;
  logic [2*`DATA_W-1:0]  pramdbi_16;
  logic [`DATA_W-1:0]    pramdbo_8;

  // Expected VRAM contents
  logic [`DATA_W-1:0]    shadow [0:(1 << `VRAM_AW)-1];
  bit                    written [0:(1 << `VRAM_AW)-1];
  logic [`VRAM_AW-1:0]   cur_addr;
  integer                seed = 32'hd673;

  int                    errors;
  int                    checks;
  int                    test_errors;
  int                    test_checks;
  int                    test_num;
  int                    tests_failed;
  string                 test_name;

  // Pending DBI comparison
  bit                    cmp_armed;
  logic [`DATA_W-1:0]    cmp_exp;
  string                 cmp_what;

  // Expected RAM pins for the next write strobe
  bit                    wr_armed;
  logic [`VRAM_AW-1:0]   wr_exp_addr;
  logic [`DATA_W-1:0]    wr_exp_data;

  vdp_core dut_i (
    .RESET      (reset),
    .CLK21M     (clk21m),
    .REQ        (req),
    .ACK        (ack),
    .WRT        (wrt),
    .mode       (mode),
    .DBI        (dbi),
    .DBO        (dbo),
    .INT_N      (int_n),
    .PRAMWE_N   (pramwe_n),
    .PRAMADR    (pramadr),
    .PRAMDBI_16 (pramdbi_16),
    .PRAMDBO_8  (pramdbo_8)
  );

  vram_model ram_i (
    .clk  (reset),
    .adr  (pramadr),
    .dbo  (pramdbo_8),
    .we_n (pramwe_n),
    .dbi  (pramdbi_16)
  );

  initial begin
    reset = 1'b0;
    forever #(clk_ns / 2) reset = ~reset;
  end

  initial begin
    #(watchdog_ns);
    $display("ERROR: watchdog expired, the run did not finish in time");
    $display("Verification failed");
    $finish;
  end

  // Expected byte from the shadow copy or 0 if never written
  function automatic logic [`DATA_W-1:0] expect_byte(input logic [`VRAM_AW-1:0] a);
    if (written[a]) begin
      return shadow[a];
    end else begin
      return '0;
    end
  endfunction

  // Compare DBI in the middle of the ACK cycle
  always @(negedge reset) begin
    if (cmp_armed && ack) begin
      checks++;
      test_checks++;
      if (dbi !== cmp_exp) begin
        $display("MISMATCH DBI: got %h, expected %h (%s)", dbi, cmp_exp, cmp_what);
        errors++;
        test_errors++;
      end
      cmp_armed = 1'b0;
    end
  end

  // Check the RAM pins while the write strobe is low
  always @(negedge reset) begin
    if (wr_armed && !pramwe_n) begin
      checks++;
      test_checks++;
      if (pramadr[`VRAM_AW-1:0] !== wr_exp_addr) begin
        $display("MISMATCH PRAMADR: got %h, expected %h", pramadr, wr_exp_addr);
        errors++;
        test_errors++;
      end
      if (pramdbo_8 !== wr_exp_data) begin
        $display("MISMATCH PRAMDBO_8: got %h, expected %h", pramdbo_8, wr_exp_data);
        errors++;
        test_errors++;
      end
      wr_armed = 1'b0;
    end
  end

  //----------------------------------------------------------
  // Bus helpers
  //----------------------------------------------------------
  task automatic tick(input int n);
    repeat (n) @(posedge reset);
    #5;
  endtask

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_sig(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      count_error();
    end
  endtask

  task automatic bus_cycle(input port_mode_e m, input logic w, input logic [7:0] d,
                           input string what, output bit got);
    int n;
    tick(1);
    mode = m;
    wrt  = w;
    dbo  = d;
    req  = 1'b1;
    tick(1);
    req = 1'b0;
    n = 1;
    while (!ack && n < ack_limit) begin
      tick(1);
      n++;
    end
    got = ack;
    if (!got) begin
      $display("ERROR: no ACK within %0d cycles of a %s request", ack_limit, what);
      count_error();
    end
  endtask

  task automatic write_ctrl(input logic [7:0] d);
    bit got;
    bus_cycle(pm_ctrl, 1'b1, d, "control write", got);
  endtask

  task automatic write_data(input logic [7:0] d);
    bit got;
    wr_exp_addr = cur_addr;
    wr_exp_data = d;
    wr_armed    = 1'b1;
    bus_cycle(pm_data, 1'b1, d, "data write", got);
    if (got && wr_armed) begin
      $display("ERROR: no write strobe on PRAMWE_N before the data write ACK");
      count_error();
    end
    wr_armed = 1'b0;
    shadow[cur_addr]  = d;
    written[cur_addr] = 1'b1;
    cur_addr = cur_addr + 1'b1;
  endtask

  task automatic read_data();
    bit got;
    cmp_exp  = expect_byte(cur_addr);
    cmp_what = $sformatf("data read at %05h", cur_addr);
    bus_cycle(pm_data, 1'b0, 8'h00, "data read", got);
    if (got) begin
      // Still inside the ACK cycle here
      cmp_armed = 1'b1;
      wait (!cmp_armed);
    end
    cur_addr = cur_addr + 1'b1;
  endtask

  task automatic read_status(input logic [7:0] exp, input bit check);
    bit got;
    cmp_exp  = exp;
    cmp_what = "status read";
    bus_cycle(pm_ctrl, 1'b0, 8'h00, "status read", got);
    if (got && check) begin
      cmp_armed = 1'b1;
      wait (!cmp_armed);
    end
  endtask

  task automatic set_reg(input logic [5:0] num, input logic [7:0] val);
    write_ctrl(val);
    write_ctrl({2'b10, num});
  endtask

  // R14 holds the top bits and bit 6 of the second byte picks write
  task automatic set_addr(input logic [`VRAM_AW-1:0] a, input bit for_write);
    set_reg(`REG_R14, {5'd0, a[16:14]});
    write_ctrl(a[7:0]);
    write_ctrl({1'b0, for_write, a[13:8]});
    cur_addr = a;
  endtask

  task automatic wait_int_low(input int limit, output bit seen);
    int n;
    n = 0;
    while (int_n !== 1'b0 && n < limit) begin
      tick(1);
      n++;
    end
    seen = (int_n === 1'b0);
  endtask

  task automatic start_test(input string name);
    test_num++;
    test_name   = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic finish_test();
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s (%0d checks, %0d errors)", test_num, test_name,
             (test_errors == 0) ? "PASS" : "FAIL", test_checks, test_errors);
  endtask

  //----------------------------------------------------------
  // Tests
  //----------------------------------------------------------
  task automatic reset_state();
    bit we_seen;
    start_test("reset state");
    check_sig("INT_N", int_n, 1'b1);
    check_sig("ACK", ack, 1'b0);
    we_seen = 1'b0;
    repeat (16) begin
      if (pramwe_n !== 1'b1) begin
        we_seen = 1'b1;
      end
      tick(1);
    end
    check_sig("PRAMWE_N", !we_seen, 1'b1);
    finish_test();
  endtask

  task automatic random_readback();
    logic [`VRAM_AW-1:0] addrs [0:39];
    start_test("random write and readback");
    for (int i = 0; i < 40; i++) begin
      addrs[i] = $random(seed);
      set_addr(addrs[i], 1'b1);
      write_data($random(seed));
    end
    for (int i = 0; i < 40; i++) begin
      set_addr(addrs[i], 1'b0);
      read_data();
    end
    finish_test();
  endtask

  // Burst across a 16 KB boundary where the R14 field goes from 2 to 3
  task automatic addr_carry();
    start_test("auto-increment");
    set_addr(17'h0BFF4, 1'b1);
    repeat (24) write_data($random(seed));
    set_addr(17'h0BFF4, 1'b0);
    repeat (24) read_data();
    set_addr(17'h0C002, 1'b0);
    read_data();
    finish_test();
  endtask

  task automatic byte_lanes();
    logic [`VRAM_AW-1:0] bases [0:3];
    logic [7:0]          v;
    start_test("byte lanes");
    for (int p = 0; p < 4; p++) begin
      bases[p] = $random(seed) & 17'h1FFFE;
      v = $random(seed);
      if (p < 2) begin
        set_addr(bases[p], 1'b1);
        write_data(v);
        write_data(~v);
      end else begin
        // Odd byte first
        set_addr(bases[p] | 17'd1, 1'b1);
        write_data(~v);
        set_addr(bases[p], 1'b1);
        write_data(v);
      end
    end
    for (int p = 0; p < 4; p++) begin
      set_addr(bases[p], 1'b0);
      read_data();
      read_data();
    end
    finish_test();
  endtask

  task automatic frame_irq();
    bit seen;
    bit stayed_high;
    start_test("frame interrupt");
    set_reg(`REG_R15, 8'h00);
    // Drop a frame flag left over from earlier frames
    read_status(8'h00, 1'b0);
    set_reg(`REG_R1, 8'h01 << `R1_IE0_BIT);
    wait_int_low(frame_cycles + 8, seen);
    if (!seen) begin
      $display("ERROR: INT_N did not go low within one frame with R1 bit 5 set");
      count_error();
    end
    read_status(8'h80, 1'b1);
    tick(2);
    check_sig("INT_N", int_n, 1'b1);
    read_status(8'h00, 1'b1);
    set_reg(`REG_R1, 8'h00);
    stayed_high = 1'b1;
    repeat (frame_cycles + `LINE_CYCLES) begin
      if (int_n !== 1'b1) begin
        stayed_high = 1'b0;
      end
      tick(1);
    end
    check_sig("INT_N", stayed_high, 1'b1);
    finish_test();
  endtask

  task automatic line_irq();
    bit seen;
    start_test("line interrupt");
    set_reg(`REG_R19, 8'h03);
    set_reg(`REG_R15, 8'h01);
    read_status(8'h00, 1'b0);
    set_reg(`REG_R0, 8'h01 << `R0_IE1_BIT);
    wait_int_low(frame_cycles + 8, seen);
    if (!seen) begin
      $display("ERROR: INT_N did not go low within one frame with R0 bit 4 set");
      count_error();
    end
    read_status(8'h01, 1'b1);
    tick(2);
    check_sig("INT_N", int_n, 1'b1);
    read_status(8'h00, 1'b1);
    finish_test();
  endtask

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    clk21m   = 1'b1;
    req      = 1'b0;
    wrt      = 1'b0;
    mode     = pm_data;
    dbo      = '0;
    cur_addr = '0;
    errors       = 0;
    checks       = 0;
    test_num     = 0;
    tests_failed = 0;
    cmp_armed    = 1'b0;
    wr_armed     = 1'b0;
    for (int i = 0; i < (1 << `VRAM_AW); i++) begin
      shadow[i]  = '0;
      written[i] = 1'b0;
    end
    repeat (5) @(posedge reset);
    #5;
    clk21m = 1'b0;
    tick(1);

    reset_state();
    random_readback();
    addr_carry();
    byte_lanes();
    frame_irq();
    line_irq();

    $display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
             test_num, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb/vram_model.sv
//----------------------------------------------------------
// Behavioural 16-bit RAM for the VDP testbench. Answers the
// RAM pins of vdp_core: reads are combinational, a byte
// write lands in the lane picked by address bit 0.
//----------------------------------------------------------

`include "vdp_consts.svh"

module vram_model (
  input  logic                  clk,
  input  logic [`RAM_AW-1:0]    adr,
  input  logic [`DATA_W-1:0]    dbo,
  input  logic                  we_n,
  output logic [2*`DATA_W-1:0]  dbi
);
  timeunit 1ns;
  timeprecision 100ps;

  // One word per pair of VRAM bytes
  logic [2*`DATA_W-1:0] mem [0:(1 << (`VRAM_AW-1))-1];

  initial begin
    for (int i = 0; i < (1 << (`VRAM_AW-1)); i++) begin
      mem[i] = '0;
    end
  end

  assign dbi = mem[adr[`VRAM_AW-1:1]];

  // Only the addressed lane changes
  always @(posedge clk) begin
    if (!we_n) begin
      if (adr[0]) begin
        mem[adr[`VRAM_AW-1:1]][2*`DATA_W-1:`DATA_W] <= dbo;
      end else begin
        mem[adr[`VRAM_AW-1:1]][`DATA_W-1:0] <= dbo;
      end
    end
  end

endmodule

//--- source/vdp_core.sv
//----------------------------------------------------------
// Top level of the VDP host side. Wires the host port, the
// VRAM slot unit and the frame timer to the CPU bus, the
// interrupt line and the external 16-bit RAM.
//----------------------------------------------------------

`include "vdp_consts.svh"

module vdp_core import vdp_pkg::*; (
  input  logic                  RESET,
  input  logic                  CLK21M,
  input  logic                  REQ,
  output logic                  ACK,
  input  logic                  WRT,
  input  port_mode_e            mode,
  output logic [`DATA_W-1:0]    DBI,
  input  logic [`DATA_W-1:0]    DBO,
  output logic                  INT_N,
  output logic                  PRAMWE_N,
  output logic [`RAM_AW-1:0]    PRAMADR,
  input  logic [2*`DATA_W-1:0]  PRAMDBI_16,
  output logic [`DATA_W-1:0]    PRAMDBO_8
);

  // Host port to frame timer
  logic               frame_int_en;
  logic               line_int_en;
  logic [`LINE_W-1:0] int_line;
  logic               clr_frame;
  logic               clr_line;
  logic               frame_flag;
  logic               line_flag;

  vram_req_if vram_bus_i ();

  vdp_host_port host_port_i (
    .RESET        (RESET),
    .CLK21M       (CLK21M),
    .req          (REQ),
    .wrt          (WRT),
    .mode         (mode),
    .dbo          (DBO),
    .dbi          (DBI),
    .ack          (ACK),
    .vram         (vram_bus_i.host),
    .frame_flag   (frame_flag),
    .line_flag    (line_flag),
    .frame_int_en (frame_int_en),
    .line_int_en  (line_int_en),
    .int_line     (int_line),
    .clr_frame    (clr_frame),
    .clr_line     (clr_line)
  );

  vdp_vram_slot vram_slot_i (
    .RESET     (RESET),
    .CLK21M    (CLK21M),
    .vram      (vram_bus_i.slot),
    .pram_adr  (PRAMADR),
    .pram_dbo  (PRAMDBO_8),
    .pram_we_n (PRAMWE_N),
    .pram_dbi  (PRAMDBI_16)
  );

  vdp_frame_timer frame_timer_i (
    .RESET        (RESET),
    .CLK21M       (CLK21M),
    .frame_int_en (frame_int_en),
    .line_int_en  (line_int_en),
    .int_line     (int_line),
    .clr_frame    (clr_frame),
    .clr_line     (clr_line),
    .frame_flag   (frame_flag),
    .line_flag    (line_flag),
    .int_n        (INT_N)
  );

endmodule

//--- source/vdp_frame_timer.sv
//----------------------------------------------------------
// Short line and frame counters with the frame flag (S0
// bit 7) and the line flag (S1 bit 0). INT_N is pulled low
// while a flag is set and its enable from R0 or R1 is on.
//----------------------------------------------------------

`include "vdp_consts.svh"

module vdp_frame_timer (
  input  logic               RESET,
  input  logic               CLK21M,
  input  logic               frame_int_en,
  input  logic               line_int_en,
  input  logic [`LINE_W-1:0] int_line,
  input  logic               clr_frame,
  input  logic               clr_line,
  output logic               frame_flag,
  output logic               line_flag,
  output logic               int_n
);

  localparam int cyc_w = $clog2(`LINE_CYCLES);
  localparam logic [cyc_w-1:0]   last_cycle  = cyc_w'(`LINE_CYCLES - 1);
  localparam logic [`LINE_W-1:0] last_line   = `LINE_W'(`FRAME_LINES - 1);
  localparam logic [`LINE_W-1:0] vblank_line = `LINE_W'(`VBLANK_LINE);

  logic [cyc_w-1:0]   cycle_cnt;
  logic [`LINE_W-1:0] line_cnt;
  logic               line_start;

  assign line_start = cycle_cnt == '0;

  //----------------------------------------------------------
  // Position counters
  //----------------------------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      cycle_cnt <= '0;
      line_cnt  <= '0;
    end else if (cycle_cnt == last_cycle) begin
      cycle_cnt <= '0;
      if (line_cnt == last_line) begin
        line_cnt <= '0;
      end else begin
        line_cnt <= line_cnt + 1'b1;
      end
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  //----------------------------------------------------------
  // Status flags
  //----------------------------------------------------------
  // A new event wins over a clear in the same edge
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      frame_flag <= 1'b0;
      line_flag  <= 1'b0;
    end else begin
      if (line_start && (line_cnt == vblank_line)) begin
        frame_flag <= 1'b1;
      end else if (clr_frame) begin
        frame_flag <= 1'b0;
      end

      if (line_start && (line_cnt == int_line)) begin
        line_flag <= 1'b1;
      end else if (clr_line) begin
        line_flag <= 1'b0;
      end
    end
  end

  assign int_n = !((frame_flag && frame_int_en) || (line_flag && line_int_en));

endmodule

//--- source/vdp_vram_slot.sv
//----------------------------------------------------------
// Dot state counter and the host VRAM access slot. A request
// waiting on the request bus is carried out on the external
// 16-bit RAM in the next cycle whose dot state is the slot.
//----------------------------------------------------------

`include "vdp_consts.svh"

module vdp_vram_slot import vdp_pkg::*; (
  input  logic                  RESET,
  input  logic                  CLK21M,
  vram_req_if.slot              vram,
  output logic [`RAM_AW-1:0]    pram_adr,
  output logic [`DATA_W-1:0]    pram_dbo,
  output logic                  pram_we_n,
  input  logic [2*`DATA_W-1:0]  pram_dbi
);

  logic [1:0]         dot_state;
  logic               pending;
  logic               slot_hit;
  logic [`DATA_W-1:0] lane_byte;

  // The request stays on the bus until ack catches up with req
  assign pending  = vram.req != vram.ack;
  assign slot_hit = pending && (dot_state == `ACCESS_SLOT);

  // Even addresses sit in the low lane
  assign lane_byte = vram.addr[0] ? pram_dbi[2*`DATA_W-1:`DATA_W]
                                  : pram_dbi[`DATA_W-1:0];

  //----------------------------------------------------------
  // RAM pins
  //----------------------------------------------------------
  assign pram_adr  = {{(`RAM_AW-`VRAM_AW){1'b0}}, vram.addr};
  assign pram_dbo  = vram.wdata;
  // Write strobe only for the slot cycle itself
  assign pram_we_n = !(slot_hit && (vram.op == op_write));

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dot_state <= 2'd0;
      vram.ack  <= 1'b0;
    end else begin
      // Free running, the host has no say in it
      dot_state <= dot_state + 2'd1;
      if (slot_hit) begin
        vram.ack <= ~vram.ack;
      end
    end
  end

  // Read byte lands in the same edge as the ack toggle
  always_ff @(posedge RESET) begin
    if (slot_hit && (vram.op == op_read)) begin
      vram.rdata <= lane_byte;
    end
  end

endmodule

//--- source/vdp_host_port.sv
//----------------------------------------------------------
// CPU facing port of the VDP. Decodes data and control port
// accesses, holds R0, R1, R14, R15 and R19, runs the VRAM
// address counter and the read-ahead buffer, and returns
// the S0 and S1 status bytes.
//----------------------------------------------------------

`include "vdp_consts.svh"

module vdp_host_port import vdp_pkg::*; (
  input  logic                RESET,
  input  logic                CLK21M,
  input  logic                req,
  input  logic                wrt,
  input  port_mode_e          mode,
  input  logic [`DATA_W-1:0]  dbo,
  output logic [`DATA_W-1:0]  dbi,
  output logic                ack,
  vram_req_if.host            vram,
  input  logic                frame_flag,
  input  logic                line_flag,
  output logic                frame_int_en,
  output logic                line_int_en,
  output logic [`LINE_W-1:0]  int_line,
  output logic                clr_frame,
  output logic                clr_line
);

  // Register file
  logic                r0_ie1;
  logic                r1_ie0;
  logic [2:0]          r14_hi;
  logic [3:0]          r15_sel;
  logic [`LINE_W-1:0]  r19_line;

  // Control byte pair
  ctrl_phase_e         phase;
  logic [`DATA_W-1:0]  ctrl_lat;

  // VRAM side
  logic [`VRAM_AW-1:0] addr_cnt;
  logic [`DATA_W-1:0]  dbo_q;
  logic [`DATA_W-1:0]  dbi_q;
  logic                ack_q;
  logic                wr_wait;
  logic                wr_busy;
  logic                rd_wait;
  logic                pf_wait;

  logic                pending;
  logic                ctrl_wr;
  logic                stat_rd;
  logic                data_wr;
  logic                data_rd;
  logic                other_req;
  logic                wr_want;
  logic                rd_want;
  logic                wr_done;
  logic [`DATA_W-1:0]  wr_byte;

  //----------------------------------------------------------
  // Access decode
  //----------------------------------------------------------
  assign pending   = vram.req != vram.ack;
  assign ctrl_wr   = req && (mode == pm_ctrl) && wrt;
  assign stat_rd   = req && (mode == pm_ctrl) && !wrt;
  assign data_wr   = req && (mode == pm_data) && wrt;
  assign data_rd   = req && (mode == pm_data) && !wrt;
  // Palette and indirect ports only get an ACK
  assign other_req = req && ((mode == pm_palette) || (mode == pm_indirect));

  // A data access may start in its REQ cycle or wait for the bus
  assign wr_want = data_wr || wr_wait;
  assign rd_want = data_rd || rd_wait;
  assign wr_byte = wr_wait ? dbo_q : dbo;
  assign wr_done = wr_busy && !pending;

  assign ack          = ack_q | wr_done;
  assign dbi          = dbi_q;
  assign frame_int_en = r1_ie0;
  assign line_int_en  = r0_ie1;
  assign int_line     = r19_line;

  // Bytes held across a wait
  always_ff @(posedge RESET) begin
    if (data_wr) begin
      dbo_q <= dbo;
    end
    if (ctrl_wr && (phase == ph_first)) begin
      ctrl_lat <= dbo;
    end
  end

  //----------------------------------------------------------
  // Port state, registers and VRAM requests
  //----------------------------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      r0_ie1     <= 1'b0;
      r1_ie0     <= 1'b0;
      r14_hi     <= 3'd0;
      r15_sel    <= 4'd0;
      r19_line   <= '0;
      phase      <= ph_first;
      addr_cnt   <= '0;
      dbi_q      <= '0;
      ack_q      <= 1'b0;
      wr_wait    <= 1'b0;
      wr_busy    <= 1'b0;
      rd_wait    <= 1'b0;
      pf_wait    <= 1'b0;
      clr_frame  <= 1'b0;
      clr_line   <= 1'b0;
      vram.req   <= 1'b0;
      vram.op    <= op_read;
      vram.addr  <= '0;
      vram.wdata <= '0;
    end else begin
      ack_q     <= 1'b0;
      clr_frame <= 1'b0;
      clr_line  <= 1'b0;

      if (data_wr) begin
        wr_wait <= 1'b1;
      end
      if (data_rd) begin
        rd_wait <= 1'b1;
      end
      if (data_wr || data_rd) begin
        phase <= ph_first;
      end
      if (wr_done) begin
        wr_busy <= 1'b0;
      end

      // One request on the bus at a time, prefetch goes first
      if (!pending) begin
        if (pf_wait) begin
          vram.req  <= ~vram.req;
          vram.op   <= op_read;
          vram.addr <= addr_cnt;
          pf_wait   <= 1'b0;
        end else if (wr_want) begin
          vram.req   <= ~vram.req;
          vram.op    <= op_write;
          vram.addr  <= addr_cnt;
          vram.wdata <= wr_byte;
          addr_cnt   <= addr_cnt + 1'b1;
          wr_wait    <= 1'b0;
          wr_busy    <= 1'b1;
        end else if (rd_want) begin
          // Hand out the buffer, then fetch the next byte
          dbi_q    <= vram.rdata;
          ack_q    <= 1'b1;
          addr_cnt <= addr_cnt + 1'b1;
          pf_wait  <= 1'b1;
          rd_wait  <= 1'b0;
        end
      end

      if (ctrl_wr) begin
        ack_q <= 1'b1;
        if (phase == ph_first) begin
          phase <= ph_second;
        end else begin
          phase <= ph_first;
          if (dbo[7]) begin
            // Register write, unknown numbers are dropped
            case (dbo[5:0])
              `REG_R0:  r0_ie1   <= ctrl_lat[`R0_IE1_BIT];
              `REG_R1:  r1_ie0   <= ctrl_lat[`R1_IE0_BIT];
              `REG_R14: r14_hi   <= ctrl_lat[2:0];
              `REG_R15: r15_sel  <= ctrl_lat[3:0];
              `REG_R19: r19_line <= ctrl_lat[`LINE_W-1:0];
              default:  ;
            endcase
          end else begin
            // Address set, bit 6 low means read setup
            addr_cnt <= {r14_hi, dbo[5:0], ctrl_lat};
            pf_wait  <= !dbo[6];
          end
        end
      end

      if (stat_rd) begin
        ack_q <= 1'b1;
        phase <= ph_first;
        case (r15_sel)
          4'd0: begin
            dbi_q     <= {frame_flag, {(`DATA_W-1){1'b0}}};
            clr_frame <= 1'b1;
          end
          4'd1: begin
            dbi_q    <= {{(`DATA_W-1){1'b0}}, line_flag};
            clr_line <= 1'b1;
          end
          default: dbi_q <= '0;
        endcase
      end

      if (other_req) begin
        ack_q <= 1'b1;
      end
    end
  end

endmodule

//--- source/vram_req_if.sv
//----------------------------------------------------------
// VRAM request bus between the host port and the slot unit.
// A request is pending while req and ack differ; the host
// toggles req, the slot unit toggles ack when it is done.
//----------------------------------------------------------

`include "vdp_consts.svh"

interface vram_req_if import vdp_pkg::*; ();

  // Host side, stable while a request is pending
  logic                req;
  vram_op_e            op;
  logic [`VRAM_AW-1:0] addr;
  logic [`DATA_W-1:0]  wdata;

  // Slot side
  logic                ack;
  logic [`DATA_W-1:0]  rdata;

  modport host (output req, op, addr, wdata, input ack, rdata);
  modport slot (input req, op, addr, wdata, output ack, rdata);

endinterface

//--- source/vdp_pkg.sv
//----------------------------------------------------------
// Shared enum types for the VDP host side. Modules import
// what they need with a wildcard import in their header.
//----------------------------------------------------------

package vdp_pkg;

  // Host port selected by the mode pins
  typedef enum logic [1:0] {
    pm_data     = 2'd0,
    pm_ctrl     = 2'd1,
    pm_palette  = 2'd2,
    pm_indirect = 2'd3
  } port_mode_e;

  // Which byte of a control port pair comes next
  typedef enum logic {
    ph_first  = 1'b0,
    ph_second = 1'b1
  } ctrl_phase_e;

  // Kind of access carried on the VRAM request bus
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } vram_op_e;

endpackage

//--- include/vdp_consts.svh
//----------------------------------------------------------
// Widths, register numbers and timing constants for the
// VDP host side. Include this where the macros are needed;
// the include path must point at this folder.
//----------------------------------------------------------

`ifndef VDP_CONSTS_SVH
`define VDP_CONSTS_SVH

// Bus and memory widths
`define VRAM_AW       17
`define RAM_AW        19
`define DATA_W        8

// Dot state in which the host gets its VRAM access
`define ACCESS_SLOT   2'd1

// Shortened frame timing
`define LINE_CYCLES   32
`define FRAME_LINES   12
`define VBLANK_LINE   10
`define LINE_W        4

// Register numbers that exist in this design
`define REG_R0        6'd0
`define REG_R1        6'd1
`define REG_R14       6'd14
`define REG_R15       6'd15
`define REG_R19       6'd19

// Interrupt enable bit positions
`define R0_IE1_BIT    4
`define R1_IE0_BIT    5

`endif
